// File: hw/rv_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_commit (
	input  logic			CLK,
	input  logic			RSTn,
	input  logic			hold_i,
	input  rv_pkg::rv_result_t	res_i,
	output logic [`RV_XLEN-1:0]	pc_o,
	output logic			rf_we_o,
	output logic [4:0]		rf_rd_o,
	output logic [`RV_XLEN-1:0]	rf_wd_o,
	output logic			st_en_o,
	output logic [`RV_XLEN-1:0]	st_addr_o,
	output logic [`RV_XLEN-1:0]	st_data_o
);

	logic [`RV_XLEN-1:0]	pc;

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			pc <= `RV_RESET_PC;
		else if (!hold_i)
			pc <= res_i.next_pc;	// One instruction per edge
	end

	assign pc_o = pc;

	// Frozen core writes nothing
	assign rf_we_o   = res_i.rd_we & ~hold_i;
	assign rf_rd_o   = res_i.rd;
	assign rf_wd_o   = res_i.rd_data;
	assign st_en_o   = res_i.st_en & ~hold_i;
	assign st_addr_o = res_i.st_addr;
	assign st_data_o = res_i.st_data;

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core (
	input  logic			CLK,
	input  logic			RSTn,
	input  logic			hold_i,
	input  rv_pkg::rv_load_t	load_i,
	output logic			tohost_we_o,
	output logic [`RV_XLEN-1:0]	tohost_o
);
	import rv_pkg::*;

	logic [`RV_ILEN-1:0]	inst;
	logic [`RV_XLEN-1:0]	pc;
	rv_decoded_t		dec;
	rv_result_t		res;
	logic [`RV_XLEN-1:0]	rs1_data;
	logic [`RV_XLEN-1:0]	rs2_data;
	logic			rf_we;
	logic [4:0]		rf_rd;
	logic [`RV_XLEN-1:0]	rf_wd;
	logic			st_en;
	logic [`RV_XLEN-1:0]	st_addr;
	logic [`RV_XLEN-1:0]	st_data;

	rv_memory u_memory (
		.CLK(CLK), .RSTn(RSTn), .fetch_addr_i(pc),
		.st_en_i(st_en), .st_addr_i(st_addr), .st_data_i(st_data),
		.load_i(load_i), .inst_o(inst),
		.tohost_we_o(tohost_we_o), .tohost_o(tohost_o)
	);

	rv_decode u_decode (.inst_i(inst), .dec_o(dec));

	rv_regfile u_regfile (
		.CLK(CLK), .rs1_i(dec.rs1), .rs2_i(dec.rs2),
		.we_i(rf_we), .rd_i(rf_rd), .wd_i(rf_wd),
		.rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
	);

	rv_execute u_execute (
		.dec_i(dec), .pc_i(pc), .rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data), .res_o(res)
	);

	rv_commit u_commit (
		.CLK(CLK), .RSTn(RSTn), .hold_i(hold_i), .res_i(res), .pc_o(pc),
		.rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_wd_o(rf_wd),
		.st_en_o(st_en), .st_addr_o(st_addr), .st_data_o(st_data)
	);

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode (
	input  logic [`RV_ILEN-1:0]	inst_i,
	output rv_pkg::rv_decoded_t	dec_o
);
	import rv_pkg::*;

	logic [6:0]		opc;
	logic [2:0]		funct3;
	logic [6:0]		funct7;
	logic [`RV_XLEN-1:0]	imm_i;
	logic [`RV_XLEN-1:0]	imm_s;
	logic [`RV_XLEN-1:0]	imm_b;
	logic [`RV_XLEN-1:0]	imm_u;
	logic [`RV_XLEN-1:0]	imm_j;
	logic [`RV_XLEN-1:0]	imm_sh;
	logic			is_shift;
	logic			imm_ok;
	logic			op_ok;

	function automatic rv_alu_e alu_op(input logic [2:0] f3, input logic alt);
		case (f3)
		3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
		3'b001:  alu_op = ALU_SLL;
		3'b010:  alu_op = ALU_SLT;
		3'b011:  alu_op = ALU_SLTU;
		3'b100:  alu_op = ALU_XOR;
		3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
		3'b110:  alu_op = ALU_OR;
		default: alu_op = ALU_AND;
		endcase
	endfunction

	assign opc    = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i  = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_s  = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b  = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u  = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'h000};
	assign imm_j  = {{(`RV_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_sh = {{(`RV_XLEN-6){1'b0}}, inst_i[25:20]};	// RV64 shamt

	assign is_shift = funct3[1:0] == 2'b01;
	assign imm_ok = !is_shift || funct7[6:1] == 6'b000000 ||
		(funct3[2] && funct7[6:1] == 6'b010000);
	assign op_ok = funct7 == 7'h00 ||
		(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

	always_comb begin
		dec_o.opcode  = OPC_ILLEGAL;
		dec_o.alu     = ALU_ADD;
		dec_o.branch  = BR_EQ;
		dec_o.use_imm = 1'b1;
		dec_o.rd      = inst_i[11:7];
		dec_o.rs1     = inst_i[19:15];
		dec_o.rs2     = inst_i[24:20];
		dec_o.imm     = imm_i;
		case (opc)
		OPC_LUI: begin
			dec_o.opcode = OPC_LUI;
			dec_o.imm    = imm_u;
		end
		OPC_AUIPC: begin
			dec_o.opcode = OPC_AUIPC;
			dec_o.imm    = imm_u;
		end
		OPC_JAL: begin
			dec_o.opcode = OPC_JAL;
			dec_o.imm    = imm_j;
		end
		OPC_BRANCH: begin
			if (funct3[2:1] != 2'b01) begin	// 010 and 011 unused
				dec_o.opcode = OPC_BRANCH;
				dec_o.branch = rv_branch_e'(funct3);
				dec_o.imm    = imm_b;
			end
		end
		OPC_OP_IMM: begin
			if (imm_ok) begin
				dec_o.opcode = OPC_OP_IMM;
				dec_o.alu    = alu_op(funct3, funct3[2] & funct7[5]);
				if (is_shift)
					dec_o.imm = imm_sh;
			end
		end
		OPC_OP: begin
			if (op_ok) begin
				dec_o.opcode  = OPC_OP;
				dec_o.alu     = alu_op(funct3, funct7[5]);
				dec_o.use_imm = 1'b0;
			end
		end
		OPC_STORE: begin
			if (funct3 == 3'b011) begin	// SD only
				dec_o.opcode = OPC_STORE;
				dec_o.imm    = imm_s;
			end
		end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute (
	input  rv_pkg::rv_decoded_t	dec_i,
	input  logic [`RV_XLEN-1:0]	pc_i,
	input  logic [`RV_XLEN-1:0]	rs1_data_i,
	input  logic [`RV_XLEN-1:0]	rs2_data_i,
	output rv_pkg::rv_result_t	res_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0]	op_b;
	logic [`RV_XLEN-1:0]	alu_res;
	logic [`RV_XLEN-1:0]	pc_plus4;
	logic [`RV_XLEN-1:0]	pc_target;
	logic [5:0]		shamt;
	logic			taken;

	assign op_b      = dec_i.use_imm ? dec_i.imm : rs2_data_i;
	assign shamt     = op_b[5:0];
	assign pc_plus4  = pc_i + `RV_XLEN'd4;
	assign pc_target = pc_i + dec_i.imm;	// JAL, branch and AUIPC

	always_comb begin
		case (dec_i.alu)
		ALU_ADD:  alu_res = rs1_data_i + op_b;
		ALU_SUB:  alu_res = rs1_data_i - op_b;
		ALU_SLL:  alu_res = rs1_data_i << shamt;
		ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
		ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, rs1_data_i < op_b};
		ALU_XOR:  alu_res = rs1_data_i ^ op_b;
		ALU_SRL:  alu_res = rs1_data_i >> shamt;
		ALU_SRA:  alu_res = $signed(rs1_data_i) >>> shamt;
		ALU_OR:   alu_res = rs1_data_i | op_b;
		default:  alu_res = rs1_data_i & op_b;
		endcase
	end

	always_comb begin
		case (dec_i.branch)
		BR_EQ:   taken = rs1_data_i == rs2_data_i;
		BR_NE:   taken = rs1_data_i != rs2_data_i;
		BR_LT:   taken = $signed(rs1_data_i) < $signed(rs2_data_i);
		BR_GE:   taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
		BR_LTU:  taken = rs1_data_i < rs2_data_i;
		BR_GEU:  taken = rs1_data_i >= rs2_data_i;
		default: taken = 1'b0;
		endcase
	end

	always_comb begin
		res_o.rd_we   = 1'b0;
		res_o.rd      = dec_i.rd;
		res_o.rd_data = alu_res;
		res_o.next_pc = pc_plus4;
		res_o.st_en   = 1'b0;
		res_o.st_addr = alu_res;	// rs1 + imm_s through the adder
		res_o.st_data = rs2_data_i;
		case (dec_i.opcode)
		OPC_LUI: begin
			res_o.rd_we   = 1'b1;
			res_o.rd_data = dec_i.imm;
		end
		OPC_AUIPC: begin
			res_o.rd_we   = 1'b1;
			res_o.rd_data = pc_target;
		end
		OPC_JAL: begin
			res_o.rd_we   = 1'b1;
			res_o.rd_data = pc_plus4;
			res_o.next_pc = pc_target;
		end
		OPC_BRANCH: begin
			if (taken)
				res_o.next_pc = pc_target;
		end
		OPC_OP_IMM, OPC_OP: res_o.rd_we = 1'b1;
		OPC_STORE: res_o.st_en = 1'b1;
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_memory (
	input  logic			CLK,
	input  logic			RSTn,
	input  logic [`RV_XLEN-1:0]	fetch_addr_i,
	input  logic			st_en_i,
	input  logic [`RV_XLEN-1:0]	st_addr_i,
	input  logic [`RV_XLEN-1:0]	st_data_i,
	input  rv_pkg::rv_load_t	load_i,
	output logic [`RV_ILEN-1:0]	inst_o,
	output logic			tohost_we_o,
	output logic [`RV_XLEN-1:0]	tohost_o
);

	logic [31:0]		mem [0:(1<<`RV_MEM_AW)-1];
	logic [`RV_MEM_AW-1:0]	st_lo;
	logic [`RV_MEM_AW-1:0]	st_hi;

	assign st_lo = st_addr_i[`RV_MEM_AW+1:2];
	assign st_hi = st_lo + 1'b1;

	assign inst_o = mem[fetch_addr_i[`RV_MEM_AW+1:2]];

	// Load port only used while held
	always_ff @(posedge CLK) begin
		if (load_i.we)
			mem[load_i.addr] <= load_i.data;
		if (st_en_i) begin
			mem[st_lo] <= st_data_i[31:0];
			mem[st_hi] <= st_data_i[63:32];
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			tohost_we_o <= 1'b0;
		else
			tohost_we_o <= st_en_i && st_addr_i == `RV_TOHOST_ADDR;
	end

	assign tohost_o = {mem[`RV_TOHOST_WORD + 11'd1], mem[`RV_TOHOST_WORD]};

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

	typedef enum logic [6:0] {
		OPC_ILLEGAL = 7'b0000000,	// Executes as a no-op
		OPC_LUI     = 7'b0110111,
		OPC_AUIPC   = 7'b0010111,
		OPC_JAL     = 7'b1101111,
		OPC_BRANCH  = 7'b1100011,
		OPC_OP_IMM  = 7'b0010011,
		OPC_OP      = 7'b0110011,
		OPC_STORE   = 7'b0100011
	} rv_opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} rv_alu_e;

	// Values match funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} rv_branch_e;

	typedef struct packed {
		rv_opcode_e		opcode;
		rv_alu_e		alu;
		rv_branch_e		branch;
		logic			use_imm;	// Operand b from imm
		logic [4:0]		rd;
		logic [4:0]		rs1;
		logic [4:0]		rs2;
		logic [`RV_XLEN-1:0]	imm;
	} rv_decoded_t;

	typedef struct packed {
		logic			rd_we;
		logic [4:0]		rd;
		logic [`RV_XLEN-1:0]	rd_data;
		logic [`RV_XLEN-1:0]	next_pc;
		logic			st_en;
		logic [`RV_XLEN-1:0]	st_addr;
		logic [`RV_XLEN-1:0]	st_data;
	} rv_result_t;

	typedef struct packed {
		logic			we;
		logic [`RV_MEM_AW-1:0]	addr;	// Word index
		logic [31:0]		data;
	} rv_load_t;

endpackage

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
	input  logic			CLK,
	input  logic [4:0]		rs1_i,
	input  logic [4:0]		rs2_i,
	input  logic			we_i,
	input  logic [4:0]		rd_i,
	input  logic [`RV_XLEN-1:0]	wd_i,
	output logic [`RV_XLEN-1:0]	rs1_data_o,
	output logic [`RV_XLEN-1:0]	rs2_data_o
);

	// x0 has no storage
	logic [`RV_XLEN-1:0]	regs [1:`RV_NUM_REG-1];

	always_ff @(posedge CLK) begin
		if (we_i && rd_i != 5'd0)
			regs[rd_i] <= wd_i;
	end

	assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
	assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath widths
`define RV_XLEN		64
`define RV_ILEN		32
`define RV_NUM_REG	32

// 2048 words of 32 bits
`define RV_MEM_AW	11

// Boot address, start of memory
`define RV_RESET_PC	64'h0000_0000_8000_0000

// Host mailbox, byte address and word index
`define RV_TOHOST_ADDR	64'h0000_0000_8000_1000
`define RV_TOHOST_WORD	11'h400

`endif

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_rv_core --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0

// File: tb.f
+incdir+include
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_commit.sv
hw/rv_memory.sv
hw/rv_core.sv
tests/tb_clock.sv
tests/rv_core_sva.sv
tests/tb_rv_core.sv

// File: tests/rv_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_sva (
	input  logic			CLK,
	input  logic			RSTn,
	input  logic			hold_i,
	input  logic			tohost_we_i,
	input  rv_pkg::rv_opcode_e	opcode_i,
	input  logic [63:0]		imm_i,
	input  logic [63:0]		fetch_addr_i,
	input  logic [4:0]		rs1_i,
	input  logic [4:0]		rs2_i,
	input  logic [63:0]		rs1_data_i,
	input  logic [63:0]		rs2_data_i
);
	import rv_pkg::*;

	a_strobe_width: assert property (@(posedge CLK) disable iff (!RSTn)
		tohost_we_i |=> !tohost_we_i)
		else $error("host strobe wider than one cycle");

	// Strobe follows a retired SD whose base plus offset hits the host word
	a_strobe_cause: assert property (@(posedge CLK) disable iff (!RSTn)
		tohost_we_i |-> $past(!hold_i && opcode_i == OPC_STORE &&
			rs1_data_i + imm_i == `RV_TOHOST_ADDR))
		else $error("host strobe without a store to the host address");

	a_x0_rs1: assert property (@(posedge CLK) rs1_i == 5'd0 |-> rs1_data_i == 64'd0)
		else $error("x0 read nonzero on rs1 port");

	a_x0_rs2: assert property (@(posedge CLK) rs2_i == 5'd0 |-> rs2_data_i == 64'd0)
		else $error("x0 read nonzero on rs2 port");

	a_fetch_align: assert property (@(posedge CLK) disable iff (!RSTn)
		fetch_addr_i[1:0] == 2'b00)
		else $error("fetch address not word aligned");

endmodule

// Decode, memory and register file signals as seen from the core
bind rv_core rv_core_sva u_sva (
	.CLK(CLK), .RSTn(RSTn), .hold_i(hold_i), .tohost_we_i(tohost_we_o),
	.opcode_i(dec.opcode), .imm_i(dec.imm), .fetch_addr_i(pc),
	.rs1_i(dec.rs1), .rs2_i(dec.rs2),
	.rs1_data_i(rs1_data), .rs2_data_i(rs2_data)
);

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	input  logic	rst_req_i,
	output logic	CLK,
	output logic	RSTn
);

	logic	por;

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;	// 40 ns period
	end

	initial begin
		por = 1'b1;
		repeat (5) @(posedge CLK);
		por <= 1'b0;
	end

	assign RSTn = ~(por | rst_req_i);	// Power-on or requested restart

endmodule

`default_nettype wire

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core;
	import rv_pkg::*;

	localparam int		NTEST = 5;
	localparam logic [6:0]	OP_IMM = 7'h13;

	logic		CLK;
	logic		RSTn;
	logic		rst_req;
	logic		hold_i;
	rv_load_t	load_i;
	logic		tohost_we_o;
	logic [63:0]	tohost_o;

	logic [31:0]	lfsr;
	logic [63:0]	xr [0:31];	// Model registers
	logic [31:0]	code [$];
	logic [63:0]	expq [$];
	logic [63:0]	exp_v;
	int		tstart [NTEST];
	int		tlen [NTEST];
	int		tnexp [NTEST];
	int		cur;
	int		seen;
	int		errs;
	int		checks;
	string		tname [NTEST] = '{"reset_hold", "op_imm", "op_reg", "x0_lui_auipc",
				"control_flow"};

	tb_clock u_clock (.rst_req_i(rst_req), .CLK(CLK), .RSTn(RSTn));

	rv_core DUT (
		.CLK(CLK), .RSTn(RSTn), .hold_i(hold_i), .load_i(load_i),
		.tohost_we_o(tohost_we_o), .tohost_o(tohost_o)
	);

	function automatic logic [31:0] rnd(input int nbits);
		logic		fb;
		logic [31:0]	v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];	// x^32+x^22+x^2+x+1
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [4:0] rnd_rd();
		return 5'(5 + rnd(5) % 26);	// Keeps x1..x4 and x31 intact
	endfunction

	function automatic logic [63:0] sext12(input logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [63:0] a, input logic [63:0] b);
		case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[5:0];
		3'd2: return {63'd0, $signed(a) < $signed(b)};
		3'd3: return {63'd0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt)
				return $signed(a) >>> b[5:0];
			else
				return a >> b[5:0];
		end
		3'd6: return a | b;
		default: return a & b;
		endcase
	endfunction

	function automatic logic br_ref(input logic [2:0] f3, input logic [63:0] a,
		input logic [63:0] b);
		case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_sd(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// Programs always sit at the reset address
	function automatic logic [63:0] cur_pc();
		return `RV_RESET_PC + 64'(4 * (code.size() - tstart[cur]));
	endfunction

	task automatic set_reg(input logic [4:0] rd, input logic [63:0] v);
		xr[rd] = (rd == 5'd0) ? 64'd0 : v;
	endtask

	task automatic op_imm(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		logic [11:0] enc;
		enc = imm;
		if (f3 == 3'd1 || f3 == 3'd5)
			enc = {1'b0, alt, 4'b0000, imm[5:0]};	// funct7 and shamt
		code.push_back(enc_i(enc, rs1, f3, rd, OP_IMM));
		set_reg(rd, alu_ref(f3, alt, xr[rs1], sext12(enc)));
	endtask

	task automatic op_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		code.push_back(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
		set_reg(rd, alu_ref(f3, alt, xr[rs1], xr[rs2]));
	endtask

	task automatic to_host(input logic [4:0] rs);
		code.push_back(enc_sd(12'd0, rs, 5'd31));
		expq.push_back(xr[rs]);
		tnexp[cur]++;
	endtask

	task automatic begin_prog(input int t);
		cur = t;
		tstart[t] = code.size();
		tnexp[t] = 0;
		set_reg(5'd31, cur_pc() + 64'h1000);
		code.push_back(enc_u(20'h00001, 5'd31, 7'h17));	// AUIPC to host base
	endtask

	task automatic end_prog();
		code.push_back(enc_jal(21'd0, 5'd0));	// Park in a self loop
		tlen[cur] = code.size() - tstart[cur];
	endtask

	task automatic build_all();
		logic [4:0]	rd;
		logic [4:0]	ra;
		logic [4:0]	rb;
		logic [2:0]	f3;
		logic [19:0]	u;
		logic [2:0]	brs [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		int		n;
		begin_prog(0);
		op_imm(3'd0, 1'b0, 5'd1, 5'd0, 12'(rnd(12)));
		code.push_back(enc_sd(12'd8, 5'd1, 5'd31));	// Beside the host word
		to_host(5'd1);
		end_prog();

		begin_prog(1);
		op_imm(3'd0, 1'b0, 5'd1, 5'd0, {1'b0, 11'(rnd(11))});
		op_imm(3'd0, 1'b0, 5'd2, 5'd0, {1'b1, 11'(rnd(11))});
		for (int s = 1; s <= 2; s++) begin
			for (int f = 0; f < 9; f++) begin
				rd = rnd_rd();
				op_imm((f == 8) ? 3'd5 : 3'(f), f == 8, rd, 5'(s), 12'(rnd(12)));
				to_host(rd);
			end
		end
		end_prog();

		begin_prog(2);
		op_imm(3'd0, 1'b0, 5'd1, 5'd0, {1'b0, 11'(rnd(11))});
		op_imm(3'd0, 1'b0, 5'd2, 5'd0, {1'b1, 11'(rnd(11))});
		op_imm(3'd0, 1'b0, 5'd4, 5'd0, {6'd0, 6'(rnd(6))});	// Shift amount
		for (int s = 1; s <= 2; s++) begin
			for (int f = 0; f < 10; f++) begin
				f3 = (f < 8) ? 3'(f) : ((f == 8) ? 3'd0 : 3'd5);
				rd = rnd_rd();
				op_reg(f3, f >= 8, rd, 5'(s),
					(f3 == 3'd1 || f3 == 3'd5) ? 5'd4 : 5'(3 - s));
				to_host(rd);
			end
		end
		end_prog();

		begin_prog(3);
		op_imm(3'd0, 1'b0, 5'd0, 5'd0, 12'(rnd(12)));
		to_host(5'd0);
		u = {1'b1, 19'(rnd(19))};
		set_reg(5'd5, {{32{u[19]}}, u, 12'h000});
		code.push_back(enc_u(u, 5'd5, 7'h37));
		to_host(5'd5);
		u = {1'b1, 19'(rnd(19))};	// Negative offset
		set_reg(5'd6, cur_pc() + {{32{u[19]}}, u, 12'h000});
		code.push_back(enc_u(u, 5'd6, 7'h17));
		to_host(5'd6);
		end_prog();

		begin_prog(4);
		op_imm(3'd0, 1'b0, 5'd1, 5'd0, {1'b0, 11'(rnd(11))});
		op_imm(3'd0, 1'b0, 5'd2, 5'd0, {1'b1, 11'(rnd(11))});
		n = 0;
		for (int b = 0; b < 6; b++) begin
			for (int want = 1; want >= 0; want--) begin
				for (int p = 0; p < 3; p++) begin
					ra = (p == 2) ? 5'd2 : 5'd1;
					rb = (p == 1) ? 5'd2 : 5'd1;
					if (br_ref(brs[b], xr[ra], xr[rb]) == want[0])
						break;
				end
				code.push_back(enc_b(13'd12, rb, ra, brs[b]));
				code.push_back(enc_i(12'(2 * n + 1), 5'd0, 3'd0, 5'd3, OP_IMM));
				code.push_back(enc_sd(12'd0, 5'd3, 5'd31));
				if (want == 0) begin
					set_reg(5'd3, 64'(2 * n + 1));
					expq.push_back(xr[3]);
					tnexp[cur]++;
				end
				op_imm(3'd0, 1'b0, 5'd3, 5'd0, 12'(2 * n + 2));
				to_host(5'd3);
				n++;
			end
		end
		set_reg(5'd7, cur_pc() + 64'd4);
		code.push_back(enc_jal(21'd8, 5'd7));
		code.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd7, OP_IMM));	// Skipped
		to_host(5'd7);
		end_prog();
	endtask

	task automatic run_test(input int t);
		int e0;
		int s0;
		e0 = errs;
		s0 = seen;
		@(posedge CLK);
		rst_req <= 1'b1;	// Restart pc under hold
		@(posedge CLK);
		rst_req <= 1'b0;
		for (int i = 0; i < tlen[t]; i++) begin
			@(posedge CLK);
			load_i.we <= 1'b1;
			load_i.addr <= 11'(i);
			load_i.data <= code[tstart[t] + i];
		end
		@(posedge CLK);
		load_i.we <= 1'b0;
		hold_i <= 1'b0;
		while (seen - s0 < tnexp[t])
			@(posedge CLK);
		repeat (4) @(posedge CLK);	// Room for stray strobes
		hold_i <= 1'b1;
		$display("test %0d %s: %0d of %0d host writes, %0d errors",
			t, tname[t], seen - s0, tnexp[t], errs - e0);
	endtask

	always @(posedge CLK) begin
		if (!RSTn || hold_i) begin
			assert (!tohost_we_o) else begin
				errs++;
				$display("ERR %0t tohost_we_o expected 0 actual %b", $time, tohost_we_o);
			end
		end else if (tohost_we_o) begin
			if (expq.size() == 0) begin
				errs++;
				$display("%0t: host write arrived with no value left to expect", $time);
			end else begin
				exp_v = expq.pop_front();
				checks++;
				seen++;
				assert (tohost_o == exp_v) else begin
					errs++;
					$display("ERR %0t tohost_o expected %h actual %h",
						$time, exp_v, tohost_o);
				end
			end
		end
	end

	initial begin
		longint limit_ns;
		hold_i = 1'b1;
		load_i = '0;
		rst_req = 1'b0;
		lfsr = 32'h33a6_3232;
		seen = 0;
		errs = 0;
		checks = 0;
		build_all();
		limit_ns = 64'(code.size() + 20) * 40 * 4;
		fork
			begin
				#(limit_ns);
				$display("Watchdog expired before all host writes arrived");
				$display("TEST FAILED");
				$finish;
			end
		join_none
		wait (RSTn === 1'b1);
		for (int t = 0; t < NTEST; t++)
			run_test(t);
		$display("%0d tests, %0d checks, %0d errors, %0d values never written",
			NTEST, checks, errs, expq.size());
		if (errs == 0 && expq.size() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
